// File: logic/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// commit lanes retired per cycle
`define COMMIT_WIDTH 4

// logical registers, also the depth of the map table
`define LOG_REGS 32
`define LOG_BITS 5

// physical register file size
`define PHYS_REGS 64
`define PHYS_BITS 6

// repair lanes into the speculative rename table
`define N_REPAIR_PACKETS 4
// cycles to sweep the table, one entry per lane per cycle
`define N_REPAIR_CYCLES (`LOG_REGS / `N_REPAIR_PACKETS)

`endif

// File: logic/rename_pkg.sv
`include "rename_config.svh"

package rename_pkg;

  //////////////////////////////////////////////////
  // register indices
  //////////////////////////////////////////////////

  // index into the architectural map table
  typedef logic [`LOG_BITS-1:0] logReg_t;

  // index into the physical register file
  typedef logic [`PHYS_BITS-1:0] physReg_t;

  //////////////////////////////////////////////////
  // commit side
  //////////////////////////////////////////////////

  // one retiring instruction and the mapping it made
  typedef struct packed {
    logic     valid;
    logReg_t  logDest;
    physReg_t phyDest;
  } commitPkt_t;

  // register handed back to the free list
  typedef struct packed {
    logic     valid;
    physReg_t regId;
  } freedReg_t;

endpackage

// File: logic/repair_pkg.sv
`include "rename_config.svh"

package repair_pkg;

  // one write into the speculative rename table
  typedef struct packed {
    logic [`LOG_BITS-1:0]  logAddr;
    logic [`PHYS_BITS-1:0] phyData;
  } repairPkt_t;

  // recovery sweep control
  // idle until a recover pulse, then repair for the sweep length
  typedef enum logic {
    IDLE,
    REPAIR
  } repairState_t;

endpackage

// File: logic/commit_if.sv
`timescale 1ns/1ps
`include "rename_config.svh"

interface commit_if;

  // commit window, lane 0 oldest, lane 3 youngest
  rename_pkg::commitPkt_t lanes [`COMMIT_WIDTH];

  // per lane table write, set only for the youngest writer of a register
  logic [`COMMIT_WIDTH-1:0] writeEn;

  // duplicate check looks at the window and decides the writers
  modport filter (
    input  lanes,
    output writeEn
  );

  // map table consumes both the lanes and the decision
  modport mapTable (
    input lanes,
    input writeEn
  );

endinterface

// File: logic/commitFilter.sv
`timescale 1ns/1ps

module commitFilter (
  commit_if.filter lanes
);

  //////////////////////////////////////////////////
  // pairwise destination compare
  //////////////////////////////////////////////////

  // older lane hits a younger valid lane with same logDest
  // naming is matchOY, older index then younger index
  logic match01;
  logic match02;
  logic match03;
  logic match12;
  logic match13;
  logic match23;

  always_comb
  begin
    // lane 0 against every younger lane
    match01 = lanes.lanes[1].valid &&
              (lanes.lanes[0].logDest == lanes.lanes[1].logDest);
    match02 = lanes.lanes[2].valid &&
              (lanes.lanes[0].logDest == lanes.lanes[2].logDest);
    match03 = lanes.lanes[3].valid &&
              (lanes.lanes[0].logDest == lanes.lanes[3].logDest);

    // lane 1 against lanes 2 and 3
    match12 = lanes.lanes[2].valid &&
              (lanes.lanes[1].logDest == lanes.lanes[2].logDest);
    match13 = lanes.lanes[3].valid &&
              (lanes.lanes[1].logDest == lanes.lanes[3].logDest);

    // lane 2 only has lane 3 above it
    match23 = lanes.lanes[3].valid &&
              (lanes.lanes[2].logDest == lanes.lanes[3].logDest);
  end

  //////////////////////////////////////////////////
  // write decision
  //////////////////////////////////////////////////

  // a lane writes when valid and nobody younger overwrites it
  // a blocked lane later frees its own phyDest instead
  always_comb
  begin
    lanes.writeEn[0] = lanes.lanes[0].valid && !(match01 || match02 || match03);
    lanes.writeEn[1] = lanes.lanes[1].valid && !(match12 || match13);
    lanes.writeEn[2] = lanes.lanes[2].valid && !match23;
    // youngest lane always wins
    lanes.writeEn[3] = lanes.lanes[3].valid;
  end

endmodule

// File: logic/archMapRam.sv
`timescale 1ns/1ps
`include "rename_config.svh"

module archMapRam (
  input  logic                  clk,
  input  logic                  reset,
  commit_if.mapTable            lanes,
  input  logic                  repairActive_i,
  input  rename_pkg::logReg_t   repairAddr_i [`N_REPAIR_PACKETS],
  output rename_pkg::physReg_t  repairData_o [`N_REPAIR_PACKETS],
  input  rename_pkg::logReg_t   debugAddr_i,
  output rename_pkg::physReg_t  debugData_o,
  output rename_pkg::freedReg_t freed_o [`COMMIT_WIDTH],
  output logic                  ready_o
);

  typedef enum logic [1:0] {
    INIT_START,
    INIT_RUN,
    INIT_DONE
  } initState_t;

  localparam rename_pkg::logReg_t LAST_ENTRY = rename_pkg::logReg_t'(`LOG_REGS - 1);

  // the architectural map, one physical register per logical one
  rename_pkg::physReg_t amtEntry [`LOG_REGS];

  initState_t          initState;
  initState_t          initNext;
  rename_pkg::logReg_t initAddr;
  rename_pkg::logReg_t initAddrNext;
  logic                initRun;

  logic                 wrEn   [`COMMIT_WIDTH];
  rename_pkg::logReg_t  wrAddr [`COMMIT_WIDTH];
  rename_pkg::physReg_t wrData [`COMMIT_WIDTH];

  rename_pkg::logReg_t  rdAddr [`COMMIT_WIDTH];
  rename_pkg::physReg_t rdData [`COMMIT_WIDTH];

  //////////////////////////////////////////////////
  // init sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      initState <= INIT_START;
      initAddr  <= '0;
    end
    else
    begin
      initState <= initNext;
      initAddr  <= initAddrNext;
    end
  end

  // start: one idle cycle, run: entry k gets k, done: hold
  always_comb
  begin
    initNext     = initState;
    initAddrNext = initAddr;
    initRun      = 1'b0;
    case (initState)
      INIT_START:
      begin
        initNext     = INIT_RUN;
        initAddrNext = '0;
      end
      INIT_RUN:
      begin
        initRun      = 1'b1;
        initAddrNext = initAddr + 1'b1;
        if (initAddr == LAST_ENTRY)
          initNext = INIT_DONE;
      end
      INIT_DONE:
      begin
        initAddrNext = '0;
      end
      default:
      begin
        initNext = INIT_START;
      end
    endcase
  end

  // table usable once every entry holds its identity mapping
  assign ready_o = (initState == INIT_DONE);

  //////////////////////////////////////////////////
  // write ports
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      // commits only after init, filter already picked the writers
      wrEn[i]   = ready_o && lanes.writeEn[i];
      wrAddr[i] = lanes.lanes[i].logDest;
      wrData[i] = lanes.lanes[i].phyDest;
    end
    // sequencer takes over port 0 while filling
    if (initRun)
    begin
      wrEn[0]   = 1'b1;
      wrAddr[0] = initAddr;
      wrData[0] = rename_pkg::physReg_t'(initAddr);
    end
  end

  // enabled lanes never share an address, so port order does not matter
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      if (wrEn[i])
        amtEntry[wrAddr[i]] <= wrData[i];
    end
  end

  //////////////////////////////////////////////////
  // read ports
  //////////////////////////////////////////////////

  // repair borrows the commit read ports, no commits arrive during a sweep
  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      rdAddr[i] = repairActive_i ? repairAddr_i[i] : lanes.lanes[i].logDest;
      rdData[i] = amtEntry[rdAddr[i]];
    end
  end

  always_comb
  begin
    for (int j = 0; j < `N_REPAIR_PACKETS; j++)
      repairData_o[j] = rdData[j];
  end

  // writer frees the mapping it replaces, a blocked lane frees its own
  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      freed_o[i].valid = lanes.lanes[i].valid;
      freed_o[i].regId = lanes.writeEn[i] ? rdData[i] : lanes.lanes[i].phyDest;
    end
  end

  // debug read, no port sharing
  assign debugData_o = amtEntry[debugAddr_i];

endmodule

// File: logic/repairSequencer.sv
`timescale 1ns/1ps
`include "rename_config.svh"

module repairSequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                recover_i,
  output logic                repairActive_o,
  output rename_pkg::logReg_t repairAddr_o [`N_REPAIR_PACKETS]
);

  // one extra bit so the counter never wraps into a stuck sweep
  localparam int CNT_BITS = $clog2(`N_REPAIR_CYCLES) + 1;
  localparam logic [CNT_BITS-1:0] LAST_CYCLE = CNT_BITS'(`N_REPAIR_CYCLES - 1);

  repair_pkg::repairState_t state;
  repair_pkg::repairState_t nextState;
  logic [CNT_BITS-1:0]      repairCount;
  logic                     incCount;
  logic                     clearCount;

  //////////////////////////////////////////////////
  // sweep FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    nextState      = state;
    repairActive_o = 1'b0;
    incCount       = 1'b0;
    clearCount     = 1'b0;
    case (state)
      repair_pkg::IDLE:
      begin
        // sweep starts in the pulse cycle itself
        if (recover_i)
        begin
          nextState      = repair_pkg::REPAIR;
          repairActive_o = 1'b1;
          incCount       = 1'b1;
        end
      end
      repair_pkg::REPAIR:
      begin
        // further pulses fall through here unseen
        repairActive_o = 1'b1;
        if (repairCount == LAST_CYCLE)
        begin
          nextState  = repair_pkg::IDLE;
          clearCount = 1'b1;
        end
        else
          incCount = 1'b1;
      end
      default:
      begin
        nextState = repair_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= repair_pkg::IDLE;
      repairCount <= '0;
    end
    else
    begin
      state <= nextState;
      if (clearCount)
        repairCount <= '0;
      else if (incCount)
        repairCount <= repairCount + 1'b1;
    end
  end

  // each lane walks its own segment, base j*N_REPAIR_CYCLES
  always_comb
  begin
    for (int j = 0; j < `N_REPAIR_PACKETS; j++)
      repairAddr_o[j] = rename_pkg::logReg_t'(j * `N_REPAIR_CYCLES) +
                        rename_pkg::logReg_t'(repairCount);
  end

endmodule

// File: logic/archRenameTop.sv
`timescale 1ns/1ps
`include "rename_config.svh"

module archRenameTop (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`COMMIT_WIDTH-1:0] commitValid_i,
  input  rename_pkg::logReg_t      commitLogDest_i [`COMMIT_WIDTH],
  input  rename_pkg::physReg_t     commitPhyDest_i [`COMMIT_WIDTH],
  input  logic                     recover_i,
  input  rename_pkg::logReg_t      debugAddr_i,
  output rename_pkg::physReg_t     debugData_o,
  output logic [`COMMIT_WIDTH-1:0] freedValid_o,
  output rename_pkg::physReg_t     freedReg_o [`COMMIT_WIDTH],
  output logic                     repairValid_o,
  output rename_pkg::logReg_t      repairAddr_o [`N_REPAIR_PACKETS],
  output rename_pkg::physReg_t     repairData_o [`N_REPAIR_PACKETS],
  output logic                     ready_o
);

  commit_if commitBus ();

  logic                  repairActive;
  rename_pkg::logReg_t   repairAddr [`N_REPAIR_PACKETS];
  rename_pkg::freedReg_t freed      [`COMMIT_WIDTH];

  // pack the flat commit ports into lanes
  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      commitBus.lanes[i].valid   = commitValid_i[i];
      commitBus.lanes[i].logDest = commitLogDest_i[i];
      commitBus.lanes[i].phyDest = commitPhyDest_i[i];
    end
  end

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////

  commitFilter filter0 (
    .lanes (commitBus.filter)
  );

  archMapRam amt0 (
    .clk            (clk),
    .reset          (reset),
    .lanes          (commitBus.mapTable),
    .repairActive_i (repairActive),
    .repairAddr_i   (repairAddr),
    .repairData_o   (repairData_o),
    .debugAddr_i    (debugAddr_i),
    .debugData_o    (debugData_o),
    .freed_o        (freed),
    .ready_o        (ready_o)
  );

  repairSequencer repair0 (
    .clk            (clk),
    .reset          (reset),
    .recover_i      (recover_i),
    .repairActive_o (repairActive),
    .repairAddr_o   (repairAddr)
  );

  // unpack freed registers for the free list
  always_comb
  begin
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      freedValid_o[i] = freed[i].valid;
      freedReg_o[i]   = freed[i].regId;
    end
  end

  // repair packets leave with the addresses that produced them
  assign repairValid_o = repairActive;
  assign repairAddr_o  = repairAddr;

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 10
) (
  input  logic resetReq_i,
  output logic clk_o,
  output logic reset_o
);

  // free running clock, starts low
  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset for RESET_CYCLES rising edges, released just after an edge
  // a request pulse starts the same sequence again
  initial
  begin
    reset_o = 1'b1;
    forever
    begin
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      reset_o = 1'b0;
      @(posedge resetReq_i);
      reset_o = 1'b1;
    end
  end

endmodule

// File: bench/archRename_chk.sv
`timescale 1ns/1ps
`include "rename_config.svh"

module archRename_chk (
  input logic                     clk,
  input logic                     reset,
  input logic [`COMMIT_WIDTH-1:0] commitValid_i,
  input logic [`COMMIT_WIDTH-1:0] freedValid_i,
  input logic                     repairValid_i,
  input logic                     ready_i
);

  // cycles in a row with repairValid high
  int highCount;
  int assertFailCount = 0;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      highCount <= 0;
    else if (repairValid_i)
      highCount <= highCount + 1;
    else
      highCount <= 0;
  end

  //////////////////////////////////////////////////
  // sweep length bound
  repairLength: assert property (@(posedge clk) disable iff (reset)
    highCount <= `N_REPAIR_CYCLES)
  else
  begin
    assertFailCount++;
    $error("repair sweep longer than N_REPAIR_CYCLES");
  end

  // freed register only for a committing lane
  freedNeedsCommit: assert property (@(posedge clk) disable iff (reset)
    (freedValid_i & ~commitValid_i) == '0)
  else
  begin
    assertFailCount++;
    $error("freedValid set on a lane without commitValid");
  end

  // ready is sticky until the next reset
  readySticky: assert property (@(posedge clk) disable iff (reset)
    ready_i |=> ready_i)
  else
  begin
    assertFailCount++;
    $error("ready dropped without reset");
  end

endmodule

// File: bench/archRename_tb.sv
`timescale 1ns/1ps
`include "rename_config.svh"

module archRename_tb;

  localparam int PERIOD        = 100;
  localparam int RESET_CYCLES  = 10;
  localparam int N_SINGLE      = 200;
  localparam int N_DUP         = 300;
  localparam int N_SWEEPS      = 5;
  localparam int SWEEP_WINDOWS = 20;
  // narrow destination range gives lots of collisions
  localparam int DUP_RANGE     = 6;

  // cycle budget of each test
  localparam int INIT_CYCLES  = `LOG_REGS + 2 + `LOG_REGS;
  localparam int SWEEP_CYCLES = N_SWEEPS * (SWEEP_WINDOWS + `N_REPAIR_CYCLES + 3);
  localparam int RESET_TEST   = RESET_CYCLES + INIT_CYCLES + 2;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + `LOG_REGS + 2 +
    2 * (INIT_CYCLES + N_SINGLE + N_DUP + SWEEP_CYCLES + RESET_TEST);

  logic                     clk;
  logic                     reset;
  logic                     resetReq;
  logic [`COMMIT_WIDTH-1:0] commitValid;
  rename_pkg::logReg_t      commitLogDest [`COMMIT_WIDTH];
  rename_pkg::physReg_t     commitPhyDest [`COMMIT_WIDTH];
  logic                     recover;
  rename_pkg::logReg_t      debugAddr;
  rename_pkg::physReg_t     debugData;
  logic [`COMMIT_WIDTH-1:0] freedValid;
  rename_pkg::physReg_t     freedReg [`COMMIT_WIDTH];
  logic                     repairValid;
  rename_pkg::logReg_t      repairAddr [`N_REPAIR_PACKETS];
  rename_pkg::physReg_t     repairData [`N_REPAIR_PACKETS];
  logic                     ready;

  // reference copy of the map table
  rename_pkg::physReg_t refMap [`LOG_REGS];

  int    seed = 32'h6d21;
  string testName;
  int    testErrors;
  int    errorCount;
  int    checkCount;
  int    testCount;

  clockGen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk0 (
    .resetReq_i (resetReq),
    .clk_o      (clk),
    .reset_o    (reset)
  );

  archRenameTop dut0 (
    .clk             (clk),
    .reset           (reset),
    .commitValid_i   (commitValid),
    .commitLogDest_i (commitLogDest),
    .commitPhyDest_i (commitPhyDest),
    .recover_i       (recover),
    .debugAddr_i     (debugAddr),
    .debugData_o     (debugData),
    .freedValid_o    (freedValid),
    .freedReg_o      (freedReg),
    .repairValid_o   (repairValid),
    .repairAddr_o    (repairAddr),
    .repairData_o    (repairData),
    .ready_o         (ready)
  );

  bind archRenameTop archRename_chk chk0 (
    .clk           (clk),
    .reset         (reset),
    .commitValid_i (commitValid_i),
    .freedValid_i  (freedValid_o),
    .repairValid_i (repairValid_o),
    .ready_i       (ready_o)
  );

  //////////////////////////////////////////////////
  // bookkeeping and compares
  //////////////////////////////////////////////////

  function automatic int randBelow(input int n);
    randBelow = int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  task automatic startTest(input string name);
    testName   = name;
    testErrors = 0;
  endtask

  task automatic reportTest();
    testCount++;
    $display("test %s done: %0d errors", testName, testErrors);
  endtask

  task automatic noteFailure(input string what);
    errorCount++;
    testErrors++;
    $display("%s: %s", testName, what);
  endtask

  task automatic checkMapping(input rename_pkg::logReg_t addr,
                              input rename_pkg::physReg_t expVal,
                              input rename_pkg::physReg_t actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      errorCount++;
      testErrors++;
      $display("error %s entry %0d: expected %h, actual %h", testName, addr, expVal, actVal);
    end
  endtask

  // regId only matters on a valid lane
  task automatic checkFreed(input int lane,
                            input rename_pkg::freedReg_t expVal,
                            input rename_pkg::freedReg_t actVal);
    checkCount++;
    if (actVal.valid !== expVal.valid || (expVal.valid && actVal.regId !== expVal.regId))
    begin
      errorCount++;
      testErrors++;
      $display("error %s freed lane %0d: expected %b/%h, actual %b/%h", testName, lane,
               expVal.valid, expVal.regId, actVal.valid, actVal.regId);
    end
  endtask

  task automatic checkRepair(input int lane,
                             input repair_pkg::repairPkt_t expVal,
                             input repair_pkg::repairPkt_t actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      errorCount++;
      testErrors++;
      $display("error %s repair lane %0d: expected %h/%h, actual %h/%h", testName, lane,
               expVal.logAddr, expVal.phyData, actVal.logAddr, actVal.phyData);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic driveIdle();
    commitValid = '0;
    recover     = 1'b0;
  endtask

  // waits out reset, times ready and reads back every entry
  task automatic checkInit();
    int cycles;
    cycles = 0;
    driveIdle();
    @(negedge reset);
    while (!ready && cycles <= `LOG_REGS + 4)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles != `LOG_REGS + 1)
    begin
      errorCount++;
      testErrors++;
      $display("error %s ready delay: expected %0d, actual %0d", testName,
               `LOG_REGS + 1, cycles);
    end
    for (int a = 0; a < `LOG_REGS; a++)
    begin
      @(posedge clk);
      #1;
      debugAddr = rename_pkg::logReg_t'(a);
      @(negedge clk);
      checkMapping(debugAddr, rename_pkg::physReg_t'(a), debugData);
    end
    for (int a = 0; a < `LOG_REGS; a++)
      refMap[a] = rename_pkg::physReg_t'(a);
  endtask

  // one commit window where the youngest lane wins a shared destination
  task automatic randomWindow(input bit singleLane, input int destRange);
    int                    pick;
    logic [`COMMIT_WIDTH-1:0] writer;
    rename_pkg::freedReg_t expFreed [`COMMIT_WIDTH];
    rename_pkg::freedReg_t actFreed;
    rename_pkg::physReg_t  expDebug;
    @(posedge clk);
    #1;
    pick = randBelow(`COMMIT_WIDTH);
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      commitValid[i]   = singleLane ? (i == pick) : (randBelow(2) == 1);
      commitLogDest[i] = rename_pkg::logReg_t'(randBelow(destRange));
      commitPhyDest[i] = rename_pkg::physReg_t'(randBelow(`PHYS_REGS));
    end
    debugAddr = rename_pkg::logReg_t'(randBelow(`LOG_REGS));
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      writer[i] = commitValid[i];
      for (int k = i + 1; k < `COMMIT_WIDTH; k++)
        if (commitValid[k] && commitLogDest[k] == commitLogDest[i])
          writer[i] = 1'b0;
      expFreed[i].valid = commitValid[i];
      // a writer frees the old entry and a blocked lane its own register
      expFreed[i].regId = writer[i] ? refMap[commitLogDest[i]] : commitPhyDest[i];
    end
    // debug sees the table before this window lands
    expDebug = refMap[debugAddr];
    @(negedge clk);
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      actFreed.valid = freedValid[i];
      actFreed.regId = freedReg[i];
      checkFreed(i, expFreed[i], actFreed);
    end
    checkMapping(debugAddr, expDebug, debugData);
    for (int i = 0; i < `COMMIT_WIDTH; i++)
      if (writer[i])
        refMap[commitLogDest[i]] = commitPhyDest[i];
  endtask

  // recover pulse and then a second one inside the sweep
  task automatic sweepCheck();
    rename_pkg::logReg_t    addr;
    repair_pkg::repairPkt_t expPkt;
    repair_pkg::repairPkt_t actPkt;
    @(posedge clk);
    #1;
    driveIdle();
    @(negedge clk);
    if (repairValid !== 1'b0)
      noteFailure("repairValid_o was high before the recover pulse");
    for (int k = 0; k < `N_REPAIR_CYCLES; k++)
    begin
      @(posedge clk);
      #1;
      recover = (k == 0) || (k == 3);
      @(negedge clk);
      if (repairValid !== 1'b1)
        noteFailure("repairValid_o was low inside the sweep");
      for (int j = 0; j < `N_REPAIR_PACKETS; j++)
      begin
        addr           = rename_pkg::logReg_t'(j * `N_REPAIR_CYCLES + k);
        expPkt.logAddr = addr;
        expPkt.phyData = refMap[addr];
        actPkt.logAddr = repairAddr[j];
        actPkt.phyData = repairData[j];
        checkRepair(j, expPkt, actPkt);
      end
    end
    @(posedge clk);
    #1;
    recover = 1'b0;
    @(negedge clk);
    if (repairValid !== 1'b0)
      noteFailure("repairValid_o stayed high past the sweep length");
  endtask

  //////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////

  initial
  begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    resetReq   = 1'b0;
    debugAddr  = '0;
    errorCount = 0;
    checkCount = 0;
    testCount  = 0;
    driveIdle();
    for (int i = 0; i < `COMMIT_WIDTH; i++)
    begin
      commitLogDest[i] = '0;
      commitPhyDest[i] = '0;
    end

    startTest("init");
    @(negedge clk);
    if (ready !== 1'b0)
      noteFailure("ready_o was high while reset was asserted");
    checkInit();
    reportTest();

    startTest("single");
    repeat (N_SINGLE) randomWindow(1'b1, `LOG_REGS);
    reportTest();

    startTest("duplicate");
    repeat (N_DUP) randomWindow(1'b0, DUP_RANGE);
    reportTest();

    startTest("recovery");
    repeat (N_SWEEPS)
    begin
      repeat (SWEEP_WINDOWS) randomWindow(1'b0, `LOG_REGS);
      sweepCheck();
    end
    reportTest();

    // table is far from identity here
    // reset lands in the middle of a fresh sweep
    startTest("reset");
    @(posedge clk);
    #1;
    driveIdle();
    recover = 1'b1;
    @(negedge clk);
    if (repairValid !== 1'b1)
      noteFailure("repairValid_o was low after the recover pulse");
    @(posedge clk);
    #1;
    recover  = 1'b0;
    resetReq = 1'b1;
    @(negedge clk);
    if (ready !== 1'b0)
      noteFailure("ready_o stayed high after reset");
    if (repairValid !== 1'b0)
      noteFailure("repairValid_o stayed high after reset during a sweep");
    resetReq = 1'b0;
    checkInit();
    reportTest();

    if (dut0.chk0.assertFailCount != 0)
    begin
      errorCount += dut0.chk0.assertFailCount;
      $display("%0d assertion failures in the checker", dut0.chk0.assertFailCount);
    end
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+logic
logic/rename_pkg.sv
logic/repair_pkg.sv
logic/commit_if.sv
logic/commitFilter.sv
logic/archMapRam.sv
logic/repairSequencer.sv
logic/archRenameTop.sv
bench/clockGen.sv
bench/archRename_chk.sv
bench/archRename_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := archRename_tb
FILELIST  := sources.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
FAIL_MSG  := Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
